// File: src/cmt_geom_pkg.sv
package cmt_geom_pkg;

   // Commit window
   localparam int CMT_W = 4;                 // Entries examined per cycle
   localparam int CMT_CNT_W = 3;             // Holds 0..CMT_W

   // Program counter, word aligned
   localparam int PC_W = 30;

   // Register file
   localparam int DATA_W = 64;
   localparam int PRF_AW = 6;                // Physical register index

   // Opcode vectors, checked only for nonzero
   localparam int LSU_OPC_W = 4;
   localparam int EPU_OPC_W = 5;

endpackage

// File: src/cmt_ctrl_pkg.sv
package cmt_ctrl_pkg;

   import cmt_geom_pkg::*;

   // Serialized unit request state
   typedef enum logic [0:0] {
      fu_idle    = 1'b0,
      fu_pending = 1'b1
   } fu_state_t;

   // Branch predictor update record
   localparam int BPU_CNT_W = 2;             // Saturating counter
   localparam int BPU_UPD_W = PC_W + 1 + BPU_CNT_W;

   // Record layout, low to high: target, taken, counter
   localparam int BPU_TGT_LSB = 0;
   localparam int BPU_TAKEN_BIT = PC_W;
   localparam int BPU_CNT_LSB = PC_W + 1;

endpackage

// File: src/cmt_select.sv
`timescale 1ns/1ns

module cmt_select
   import cmt_geom_pkg::*;
(
   input  logic [CMT_W-1:0]           cmt_valid,
   input  logic [CMT_W*LSU_OPC_W-1:0] cmt_lsu_opc,
   input  logic [CMT_W*EPU_OPC_W-1:0] cmt_epu_opc,
   input  logic [CMT_W-1:0]           cmt_exc,
   input  logic [CMT_W-1:0]           cmt_fls,
   input  logic [CMT_W-1:0]           cmt_is_bcc,
   input  logic [CMT_W-1:0]           cmt_is_breg,
   input  logic [CMT_W-1:0]           cmt_is_brel,
   input  logic                       se_fls,
   input  logic                       flush,
   input  logic                       pipe_finish,
   output logic [CMT_W-1:0]           cmt_fire,
   output logic [CMT_CNT_W-1:0]       cmt_pop_size,
   output logic                       pipe_req,
   output logic                       epu_pick,
   output logic                       branch_fire
);

   logic [CMT_W-1:0] lsu_req;
   logic [CMT_W-1:0] epu_req;
   logic [CMT_W-1:0] cmt_b;
   logic [CMT_W-1:0] special;
   logic [CMT_W-1:0] cmt_mask;
   logic [CMT_W-1:0] ready;
   logic             cmt_ce;

   // Per-channel decode
   always_comb
   begin
      for (int i = 0; i < CMT_W; i++)
      begin
         lsu_req[i] = ~se_fls & (|cmt_lsu_opc[i*LSU_OPC_W +: LSU_OPC_W]);
         epu_req[i] = ~se_fls & ((|cmt_epu_opc[i*EPU_OPC_W +: EPU_OPC_W]) | cmt_exc[i]);
         cmt_b[i] = cmt_is_bcc[i] | cmt_is_breg[i] | cmt_is_brel[i];
      end
   end

   // Anything that must retire alone
   assign special = lsu_req | epu_req | cmt_fls | cmt_b;

   // Head always eligible, the rest stop at the first special entry
   always_comb
   begin
      cmt_mask[0] = 1'b1;
      cmt_mask[1] = ~special[0] & ~special[1];
      for (int j = 2; j < CMT_W; j++)
      begin
         cmt_mask[j] = cmt_mask[j-1] & ~special[j];
      end
   end

   assign ready = cmt_valid & cmt_mask;

   assign pipe_req = ready[0] & (lsu_req[0] | epu_req[0]);
   assign epu_pick = ready[0] & epu_req[0];

   assign cmt_ce = ~pipe_req | pipe_finish;   // Hold while unit busy
   assign cmt_fire = ready & {CMT_W{cmt_ce & ~flush}};

   assign branch_fire = cmt_fire[0] & cmt_b[0];

   // Retire count back to the ROB
   always_comb
   begin
      cmt_pop_size = '0;
      for (int k = 0; k < CMT_W; k++)
      begin
         cmt_pop_size = cmt_pop_size + CMT_CNT_W'(cmt_fire[k]);
      end
   end

endmodule

// File: src/cmt_serial_fu.sv
`timescale 1ns/1ns

module cmt_serial_fu
   import cmt_geom_pkg::*;
   import cmt_ctrl_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              pipe_req,
   input  logic              epu_pick,
   input  logic              lsu_stall,
   input  logic              lsu_wb_valid,
   input  logic [DATA_W-1:0] lsu_wb_dout,
   input  logic              epu_wb_valid,
   input  logic [DATA_W-1:0] epu_wb_dout,
   input  logic              epu_wb_dout_sel,
   input  logic              flush,
   input  logic              prd_we0,
   input  logic [PRF_AW-1:0] prd0,
   output logic              lsu_req_valid,
   output logic              epu_req_valid,
   output logic              pipe_finish,
   output logic              prf_we,
   output logic [PRF_AW-1:0] prf_waddr,
   output logic [DATA_W-1:0] prf_wdata
);

   fu_state_t state;
   fu_state_t state_nxt;
   logic      is_idle;

   assign is_idle = (state == fu_idle);

   // Either unit reports completion
   assign pipe_finish = lsu_wb_valid | epu_wb_valid;

   always_comb
   begin
      state_nxt = state;
      case (state)
         fu_idle:
         begin
            if (pipe_req & ~lsu_stall)
            begin
               state_nxt = fu_pending;       // Request accepted
            end
         end
         fu_pending:
         begin
            if (pipe_finish)
            begin
               state_nxt = fu_idle;
            end
         end
         default:
         begin
            state_nxt = fu_idle;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= fu_idle;
      end
      else
      begin
         state <= state_nxt;
      end
   end

   // EPU operations may go through the LSU as well
   assign lsu_req_valid = is_idle & pipe_req;
   assign epu_req_valid = is_idle & epu_pick;

   // Result of the serialized entry into the PRF
   assign prf_we = pipe_finish & ~flush & prd_we0;
   assign prf_waddr = prd0;
   assign prf_wdata = epu_wb_dout_sel ? epu_wb_dout : lsu_wb_dout;

endmodule

// File: src/cmt_redirect.sv
`timescale 1ns/1ns

module cmt_redirect
   import cmt_geom_pkg::*;
   import cmt_ctrl_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 cmt_fire0,
   input  logic                 cmt_fls0,
   input  logic [PC_W-1:0]      cmt_fls_tgt0,
   input  logic [PC_W-1:0]      cmt_pc0,
   input  logic                 cmt_is_bcc0,
   input  logic                 cmt_is_breg0,
   input  logic                 cmt_is_brel0,
   input  logic [BPU_UPD_W-1:0] cmt_bpu_upd0,
   input  logic                 branch_fire,
   input  logic                 refetch,
   input  logic                 exc_flush,
   input  logic [PC_W-1:0]      exc_flush_tgt,
   output logic                 se_fls,
   output logic                 flush,
   output logic [PC_W-1:0]      flush_tgt,
   output logic                 bpu_wb,
   output logic                 bpu_wb_is_bcc,
   output logic                 bpu_wb_is_breg,
   output logic                 bpu_wb_is_brel,
   output logic                 bpu_wb_taken,
   output logic [PC_W-1:0]      bpu_wb_pc,
   output logic [PC_W-1:0]      bpu_wb_npc_act,
   output logic [BPU_CNT_W-1:0] bpu_wb_upd_partial
);

   logic [PC_W-1:0] npc0;
   logic            se_fls_nxt;
   logic [PC_W-1:0] se_tgt_nxt;
   logic [PC_W-1:0] se_tgt;

   assign npc0 = cmt_pc0 + PC_W'(1);   // Sequential next pc

   // Set on a flushing retire, clears itself the next cycle
   assign se_fls_nxt = (cmt_fls0 | refetch) & ~se_fls;
   assign se_tgt_nxt = cmt_fls0 ? cmt_fls_tgt0 : npc0;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         se_fls <= 1'b0;
      end
      else if (cmt_fire0 | se_fls)
      begin
         se_fls <= se_fls_nxt;
      end
   end

   always_ff @(posedge clk)
   begin
      if (cmt_fire0)
      begin
         se_tgt <= se_tgt_nxt;
      end
   end

   // Self flush wins over the exception flush
   assign flush = se_fls | exc_flush;
   assign flush_tgt = se_fls ? se_tgt : exc_flush_tgt;

   // Predictor update from the head entry
   assign bpu_wb = branch_fire;
   assign bpu_wb_is_bcc = cmt_is_bcc0;
   assign bpu_wb_is_breg = cmt_is_breg0;
   assign bpu_wb_is_brel = cmt_is_brel0;
   assign bpu_wb_taken = cmt_bpu_upd0[BPU_TAKEN_BIT] ^ cmt_fls0;   // Mispredict flips it
   assign bpu_wb_pc = cmt_pc0;
   assign bpu_wb_npc_act = cmt_fls0 ? cmt_fls_tgt0 : cmt_bpu_upd0[BPU_TGT_LSB +: PC_W];
   assign bpu_wb_upd_partial = cmt_bpu_upd0[BPU_CNT_LSB +: BPU_CNT_W];

endmodule

// File: src/cmt_top.sv
`timescale 1ns/1ns

module cmt_top
   import cmt_geom_pkg::*;
   import cmt_ctrl_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst,
   // Head of the ROB
   input  logic [CMT_W-1:0]           cmt_valid,
   input  logic [CMT_W*LSU_OPC_W-1:0] cmt_lsu_opc,
   input  logic [CMT_W*EPU_OPC_W-1:0] cmt_epu_opc,
   input  logic [CMT_W-1:0]           cmt_exc,
   input  logic [CMT_W-1:0]           cmt_fls,
   input  logic [CMT_W*PC_W-1:0]      cmt_fls_tgt,
   input  logic [CMT_W*PC_W-1:0]      cmt_pc,
   input  logic [CMT_W-1:0]           cmt_is_bcc,
   input  logic [CMT_W-1:0]           cmt_is_breg,
   input  logic [CMT_W-1:0]           cmt_is_brel,
   input  logic [CMT_W*BPU_UPD_W-1:0] cmt_bpu_upd,
   input  logic [CMT_W*PRF_AW-1:0]    cmt_prd,
   input  logic [CMT_W-1:0]           cmt_prd_we,
   // External LSU and EPU
   input  logic                       lsu_stall,
   input  logic                       lsu_wb_valid,
   input  logic [DATA_W-1:0]          lsu_wb_dout,
   input  logic                       epu_wb_valid,
   input  logic [DATA_W-1:0]          epu_wb_dout,
   input  logic                       epu_wb_dout_sel,
   input  logic                       refetch,
   input  logic                       exc_flush,
   input  logic [PC_W-1:0]            exc_flush_tgt,
   // To ROB
   output logic [CMT_W-1:0]           cmt_fire,
   output logic [CMT_CNT_W-1:0]       cmt_pop_size,
   output logic                       lsu_req_valid,
   output logic                       epu_req_valid,
   // To PRF
   output logic                       prf_we,
   output logic [PRF_AW-1:0]          prf_waddr,
   output logic [DATA_W-1:0]          prf_wdata,
   // To frontend
   output logic                       flush,
   output logic [PC_W-1:0]            flush_tgt,
   output logic                       bpu_wb,
   output logic                       bpu_wb_is_bcc,
   output logic                       bpu_wb_is_breg,
   output logic                       bpu_wb_is_brel,
   output logic                       bpu_wb_taken,
   output logic [PC_W-1:0]            bpu_wb_pc,
   output logic [PC_W-1:0]            bpu_wb_npc_act,
   output logic [BPU_CNT_W-1:0]       bpu_wb_upd_partial
);

   logic se_fls;
   logic pipe_req;
   logic epu_pick;
   logic pipe_finish;
   logic branch_fire;

   cmt_select u_select (
      .cmt_valid   (cmt_valid),
      .cmt_lsu_opc (cmt_lsu_opc),
      .cmt_epu_opc (cmt_epu_opc),
      .cmt_exc     (cmt_exc),
      .cmt_fls     (cmt_fls),
      .cmt_is_bcc  (cmt_is_bcc),
      .cmt_is_breg (cmt_is_breg),
      .cmt_is_brel (cmt_is_brel),
      .se_fls      (se_fls),
      .flush       (flush),
      .pipe_finish (pipe_finish),
      .cmt_fire    (cmt_fire),
      .cmt_pop_size(cmt_pop_size),
      .pipe_req    (pipe_req),
      .epu_pick    (epu_pick),
      .branch_fire (branch_fire)
   );

   // Only the head entry is serialized
   cmt_serial_fu u_serial_fu (
      .clk            (clk),
      .rst            (rst),
      .pipe_req       (pipe_req),
      .epu_pick       (epu_pick),
      .lsu_stall      (lsu_stall),
      .lsu_wb_valid   (lsu_wb_valid),
      .lsu_wb_dout    (lsu_wb_dout),
      .epu_wb_valid   (epu_wb_valid),
      .epu_wb_dout    (epu_wb_dout),
      .epu_wb_dout_sel(epu_wb_dout_sel),
      .flush          (flush),
      .prd_we0        (cmt_prd_we[0]),
      .prd0           (cmt_prd[PRF_AW-1:0]),
      .lsu_req_valid  (lsu_req_valid),
      .epu_req_valid  (epu_req_valid),
      .pipe_finish    (pipe_finish),
      .prf_we         (prf_we),
      .prf_waddr      (prf_waddr),
      .prf_wdata      (prf_wdata)
   );

   cmt_redirect u_redirect (
      .clk               (clk),
      .rst               (rst),
      .cmt_fire0         (cmt_fire[0]),
      .cmt_fls0          (cmt_fls[0]),
      .cmt_fls_tgt0      (cmt_fls_tgt[PC_W-1:0]),
      .cmt_pc0           (cmt_pc[PC_W-1:0]),
      .cmt_is_bcc0       (cmt_is_bcc[0]),
      .cmt_is_breg0      (cmt_is_breg[0]),
      .cmt_is_brel0      (cmt_is_brel[0]),
      .cmt_bpu_upd0      (cmt_bpu_upd[BPU_UPD_W-1:0]),
      .branch_fire       (branch_fire),
      .refetch           (refetch),
      .exc_flush         (exc_flush),
      .exc_flush_tgt     (exc_flush_tgt),
      .se_fls            (se_fls),
      .flush             (flush),
      .flush_tgt         (flush_tgt),
      .bpu_wb            (bpu_wb),
      .bpu_wb_is_bcc     (bpu_wb_is_bcc),
      .bpu_wb_is_breg    (bpu_wb_is_breg),
      .bpu_wb_is_brel    (bpu_wb_is_brel),
      .bpu_wb_taken      (bpu_wb_taken),
      .bpu_wb_pc         (bpu_wb_pc),
      .bpu_wb_npc_act    (bpu_wb_npc_act),
      .bpu_wb_upd_partial(bpu_wb_upd_partial)
   );

endmodule

// File: dv/cmt_assertions.sv
`timescale 1ns/1ns

module cmt_assertions
   import cmt_geom_pkg::*;
(
   input logic             clk,
   input logic             rst,
   input logic             lsu_req_valid,
   input logic             lsu_stall,
   input logic             lsu_wb_valid,
   input logic             epu_wb_valid,
   input logic             refetch,
   input logic             exc_flush,
   input logic             flush,
   input logic [CMT_W-1:0] cmt_fls,
   input logic [CMT_W-1:0] cmt_fire
);

   int err_cnt = 0;   // Failed checks so far

   // Accepted request leaves idle, strobe drops
   a_accept: assert property (@(posedge clk) disable iff (rst)
      lsu_req_valid && !lsu_stall |=> !lsu_req_valid)
   else
   begin
      err_cnt++;
      $error("request strobe high after acceptance");
   end

   // Pending request holds the whole window
   a_hold: assert property (@(posedge clk) disable iff (rst)
      lsu_req_valid && !lsu_stall |=> cmt_fire == '0 || lsu_wb_valid || epu_wb_valid)
   else
   begin
      err_cnt++;
      $error("retire while unit request pending");
   end

   // Flushing retire redirects on the next cycle
   a_se_start: assert property (@(posedge clk) disable iff (rst)
      cmt_fire[0] && (cmt_fls[0] || refetch) |=> flush && cmt_fire == '0)
   else
   begin
      err_cnt++;
      $error("self flush missing after flushing retire");
   end

   a_se_once: assert property (@(posedge clk) disable iff (rst)
      $past(cmt_fire[0] && (cmt_fls[0] || refetch), 2) |-> flush == exc_flush)
   else
   begin
      err_cnt++;
      $error("self flush longer than one cycle");
   end

endmodule

bind cmt_top cmt_assertions cmt_assertions_inst (.*);

// File: dv/cmt_tb.sv
`timescale 1ns/1ns

module cmt_tb
   import cmt_geom_pkg::*;
   import cmt_ctrl_pkg::*;
;

   localparam int NUM_CYCLES = 3000;

   logic clk = 1'b0;
   logic rst = 1'b1;
   logic [CMT_W-1:0] cmt_valid, cmt_exc, cmt_fls, cmt_is_bcc, cmt_is_breg, cmt_is_brel;
   logic [CMT_W-1:0] cmt_prd_we;
   logic [CMT_W*LSU_OPC_W-1:0] cmt_lsu_opc;
   logic [CMT_W*EPU_OPC_W-1:0] cmt_epu_opc;
   logic [CMT_W*PC_W-1:0] cmt_fls_tgt, cmt_pc;
   logic [CMT_W*BPU_UPD_W-1:0] cmt_bpu_upd;
   logic [CMT_W*PRF_AW-1:0] cmt_prd;
   logic lsu_stall, lsu_wb_valid, epu_wb_valid, epu_wb_dout_sel, refetch, exc_flush;
   logic [DATA_W-1:0] lsu_wb_dout, epu_wb_dout;
   logic [PC_W-1:0] exc_flush_tgt;
   logic [CMT_W-1:0] cmt_fire;
   logic [CMT_CNT_W-1:0] cmt_pop_size;
   logic lsu_req_valid, epu_req_valid, prf_we, flush;
   logic [PRF_AW-1:0] prf_waddr;
   logic [DATA_W-1:0] prf_wdata;
   logic [PC_W-1:0] flush_tgt, bpu_wb_pc, bpu_wb_npc_act;
   logic bpu_wb, bpu_wb_is_bcc, bpu_wb_is_breg, bpu_wb_is_brel, bpu_wb_taken;
   logic [BPU_CNT_W-1:0] bpu_wb_upd_partial;

   // Reference model
   logic m_pend, m_se, m_flush, m_req, m_epu, finish, self_start, accept_seen, job_epu;
   logic req_held;
   logic [CMT_W-1:0] lreq, ereq, spec, elig, rdy, exp_fire;
   logic [CMT_CNT_W-1:0] exp_pop;
   logic [PC_W-1:0] self_tgt, exp_npc;
   int seed;
   int wait_cnt = 0;
   int phase;
   bit run = 1'b0;
   bit live = 1'b0;
   int hit_sel = 0, hit_pend = 0, hit_stall = 0, hit_wb = 0, hit_self = 0, hit_exc = 0;
   int hit_bpu = 0;

   cmt_top cmt_top_inst (.*);

   always #20 clk = ~clk;

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("tests failed");
      $fatal(1, "simulation stopped");
   endtask

   function automatic bit chance(input int pct);
      return ($unsigned($random(seed)) % 100) < pct;
   endfunction

   always_comb
   begin
      for (int i = 0; i < CMT_W; i++)
      begin
         lreq[i] = !m_se && (cmt_lsu_opc[i*LSU_OPC_W +: LSU_OPC_W] != '0);
         ereq[i] = !m_se && ((cmt_epu_opc[i*EPU_OPC_W +: EPU_OPC_W] != '0) || cmt_exc[i]);
         spec[i] = lreq[i] | ereq[i] | cmt_fls[i] | cmt_is_bcc[i] | cmt_is_breg[i] | cmt_is_brel[i];
      end
      elig[0] = 1'b1;
      elig[1] = !spec[0] && !spec[1];
      for (int i = 2; i < CMT_W; i++)
      begin
         elig[i] = elig[i-1] && !spec[i];
      end
      rdy = cmt_valid & elig;
      m_req = rdy[0] && (lreq[0] || ereq[0]);
      m_epu = rdy[0] && ereq[0];
      finish = lsu_wb_valid || epu_wb_valid;
      m_flush = m_se || exc_flush;
      exp_fire = ((!m_req || finish) && !m_flush) ? rdy : '0;
      exp_pop = '0;
      for (int i = 0; i < CMT_W; i++)
      begin
         exp_pop = exp_pop + CMT_CNT_W'(exp_fire[i]);
      end
      self_start = exp_fire[0] && (cmt_fls[0] || refetch);
      self_tgt = cmt_fls[0] ? cmt_fls_tgt[PC_W-1:0] : cmt_pc[PC_W-1:0] + PC_W'(1);
      exp_npc = cmt_fls[0] ? cmt_fls_tgt[PC_W-1:0] : cmt_bpu_upd[BPU_TGT_LSB +: PC_W];
   end

   always @(posedge clk)
   begin
      if (rst)
      begin
         m_pend <= 1'b0;
         m_se <= 1'b0;
         accept_seen <= 1'b0;
         req_held <= 1'b0;
      end
      else
      begin
         accept_seen <= !m_pend && m_req && !lsu_stall;   // Request taken by a unit
         req_held <= !m_pend && m_req && lsu_stall;       // Refused, window must hold
         job_epu <= m_epu;
         if (!m_pend && m_req && !lsu_stall)
            m_pend <= 1'b1;
         else if (m_pend && finish)
            m_pend <= 1'b0;
         if (exp_fire[0] || m_se)
            m_se <= (cmt_fls[0] || refetch) && !m_se;
         // Reach counters
         if (!m_flush && !m_req && rdy != '0) hit_sel++;
         if (m_pend && !finish && cmt_valid[0]) hit_pend++;
         if (lsu_req_valid && lsu_stall) hit_stall++;
         if (finish && !m_flush && cmt_prd_we[0]) hit_wb++;
         if (self_start) hit_self++;
         if (exc_flush && !m_se) hit_exc++;
         if (bpu_wb) hit_bpu++;
      end
   end

   task automatic new_window();
      int p_unit;
      int p_br;
      int p_fls;
      p_unit = (phase == 1) ? 35 : 8;
      p_br = (phase == 2) ? 30 : 8;
      p_fls = (phase == 2) ? 15 : 4;
      for (int i = 0; i < CMT_W; i++)
      begin
         cmt_valid[i] = run && chance(85);
         cmt_lsu_opc[i*LSU_OPC_W +: LSU_OPC_W] =
            chance(p_unit) ? LSU_OPC_W'($random(seed) | 1) : '0;
         cmt_epu_opc[i*EPU_OPC_W +: EPU_OPC_W] =
            chance(p_unit / 2) ? EPU_OPC_W'($random(seed) | 1) : '0;
         cmt_exc[i] = chance(2);
         cmt_fls[i] = chance(p_fls);
         cmt_is_bcc[i] = chance(p_br);
         cmt_is_breg[i] = chance(p_br / 3);
         cmt_is_brel[i] = chance(p_br / 3);
         cmt_prd_we[i] = chance(70);
         cmt_prd[i*PRF_AW +: PRF_AW] = PRF_AW'($random(seed));
         cmt_pc[i*PC_W +: PC_W] = PC_W'($random(seed));
         cmt_fls_tgt[i*PC_W +: PC_W] = PC_W'($random(seed));
         cmt_bpu_upd[i*BPU_UPD_W +: BPU_UPD_W] = BPU_UPD_W'({$random(seed), $random(seed)});
      end
   endtask

   // Stimulus and LSU/EPU response models
   always @(negedge clk)
   begin
      if (live)
      begin
         lsu_wb_valid = 1'b0;
         epu_wb_valid = 1'b0;
         refetch = 1'b0;
         if (wait_cnt > 0)
         begin
            wait_cnt--;
            if (wait_cnt == 0)
            begin
               lsu_wb_valid = !job_epu;
               epu_wb_valid = job_epu;
               epu_wb_dout_sel = job_epu && chance(80);
               refetch = job_epu && chance(30);
               lsu_wb_dout = {$random(seed), $random(seed)};
               epu_wb_dout = {$random(seed), $random(seed)};
            end
         end
         else if (accept_seen)
            wait_cnt = 1 + ($unsigned($random(seed)) % 4);
         if (!req_held && !m_pend && wait_cnt == 0 && !accept_seen)
            new_window();
         lsu_stall = chance(25);
         exc_flush = run && chance(2);
         exc_flush_tgt = PC_W'($random(seed));
      end
   end

   a_fire: assert property (@(posedge clk) disable iff (rst)
      cmt_fire == exp_fire && cmt_pop_size == exp_pop)
      else stop_on_error($sformatf("ERR %0t: fire %b count %0d, expected %b count %0d",
         $time, $sampled(cmt_fire), $sampled(cmt_pop_size), $sampled(exp_fire),
         $sampled(exp_pop)));

   a_pend: assert property (@(posedge clk) disable iff (rst)
      m_pend && !finish |-> cmt_fire == '0)
      else stop_on_error($sformatf("ERR %0t: retire while unit request pending", $time));

   a_strobe: assert property (@(posedge clk) disable iff (rst)
      lsu_req_valid == (!m_pend && m_req) && epu_req_valid == (!m_pend && m_epu))
      else stop_on_error($sformatf("ERR %0t: unit request strobe mismatch", $time));

   a_wb: assert property (@(posedge clk) disable iff (rst)
      prf_we == (finish && !m_flush && cmt_prd_we[0]) && prf_waddr == cmt_prd[PRF_AW-1:0]
      && prf_wdata == (epu_wb_dout_sel ? epu_wb_dout : lsu_wb_dout))
      else stop_on_error($sformatf("ERR %0t: register file write-back mismatch", $time));

   a_self: assert property (@(posedge clk) disable iff (rst)
      self_start |=> flush && flush_tgt == $past(self_tgt) && cmt_fire == '0)
      else stop_on_error($sformatf("ERR %0t: self flush missing or wrong target", $time));

   a_self_once: assert property (@(posedge clk) disable iff (rst)
      $past(self_start, 2) && !exc_flush |-> !flush)
      else stop_on_error($sformatf("ERR %0t: self flush longer than one cycle", $time));

   a_exc: assert property (@(posedge clk) disable iff (rst)
      exc_flush && !m_se |-> flush && flush_tgt == exc_flush_tgt && cmt_fire == '0)
      else stop_on_error($sformatf("ERR %0t: exception flush mismatch", $time));

   a_bpu: assert property (@(posedge clk) disable iff (rst)
      bpu_wb == (exp_fire[0] && (cmt_is_bcc[0] || cmt_is_breg[0] || cmt_is_brel[0]))
      && (!bpu_wb || (bpu_wb_taken == (cmt_bpu_upd[BPU_TAKEN_BIT] ^ cmt_fls[0])
      && bpu_wb_npc_act == exp_npc && bpu_wb_pc == cmt_pc[PC_W-1:0]
      && bpu_wb_upd_partial == cmt_bpu_upd[BPU_CNT_LSB +: BPU_CNT_W]
      && bpu_wb_is_bcc == cmt_is_bcc[0] && bpu_wb_is_breg == cmt_is_breg[0]
      && bpu_wb_is_brel == cmt_is_brel[0])))
      else stop_on_error($sformatf("ERR %0t: branch predictor update mismatch", $time));

   // Watch the bound checker
   always @(negedge clk)
   begin
      if (cmt_top_inst.cmt_assertions_inst.err_cnt != 0)
         stop_on_error("a bound assertion on the DUT failed");
   end

   initial
   begin
      string missing;
      int t;
      seed = 32'h1f28d7b4;
      {cmt_valid, cmt_exc, cmt_fls, cmt_is_bcc, cmt_is_breg, cmt_is_brel} = '0;
      {cmt_lsu_opc, cmt_epu_opc, cmt_fls_tgt, cmt_pc, cmt_bpu_upd} = '0;
      {cmt_prd, cmt_prd_we, lsu_stall, lsu_wb_valid, epu_wb_valid} = '0;
      {lsu_wb_dout, epu_wb_dout, epu_wb_dout_sel, refetch, exc_flush, exc_flush_tgt} = '0;
      phase = 0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(posedge clk);
      live = 1'b1;
      run = 1'b1;
      for (int c = 0; c < NUM_CYCLES; c++)
      begin
         @(posedge clk);
         phase = (c / 250) % 3;   // Weighted phases
      end
      run = 1'b0;
      t = 0;
      while ((m_pend || req_held || wait_cnt != 0) && t < 100)   // Drain outstanding request
      begin
         @(posedge clk);
         t++;
      end
      if (t >= 100)
         stop_on_error("timeout waiting for the last unit request to complete");
      @(negedge clk);
      missing = "";
      if (hit_sel == 0) missing = {missing, " retire-selection"};
      if (hit_pend == 0) missing = {missing, " serialization"};
      if (hit_stall == 0) missing = {missing, " stall"};
      if (hit_wb == 0) missing = {missing, " write-back"};
      if (hit_self == 0) missing = {missing, " self-flush"};
      if (hit_exc == 0) missing = {missing, " exception-flush"};
      if (hit_bpu == 0) missing = {missing, " branch-update"};
      if (missing != "")
         stop_on_error({"these checks were never reached:", missing});
      else
      begin
         $display("all tests passed");
         $finish;
      end
   end

endmodule

// File: list.f
src/cmt_geom_pkg.sv
src/cmt_ctrl_pkg.sv
src/cmt_select.sv
src/cmt_serial_fu.sv
src/cmt_redirect.sv
src/cmt_top.sv
dv/cmt_assertions.sv
dv/cmt_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= cmt_tb
RTL_TOP ?= cmt_top
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG ?= tests failed
PASS_MSG ?= all tests passed
VFLAGS ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
